// ==== all.f ====
+incdir+hw
hw/core_pkg.sv
hw/reg_file.sv
hw/inst_decode.sv
hw/exe.sv
hw/data_mem.sv
hw/pipe_ctrl.sv
hw/core_top.sv
tests/core_tb.sv

// ==== tests/core_stimulus.txt ====
# Columns in hex: test group, instruction, pc, expected write enable, destination, result
# Destination and result are only compared when the write enable is 1
1 24011234 00400000 1 01 00001234
1 3c02dead 00400004 1 02 dead0000
1 3442beef 00400008 1 02 deadbeef
1 3043ff0f 0040000c 1 03 0000be0f
1 3824ffff 00400010 1 04 0000edcb
1 2405fff0 00400014 1 05 fffffff0
1 00453024 00400018 1 06 deadbee0
1 00233825 0040001c 1 07 0000be3f
1 00454026 00400020 1 08 2152411f
1 00244827 00400024 1 09 ffff0000
2 00025100 00400028 1 0a eadbeef0
2 00025a02 0040002c 1 0b 00deadbe
2 00026203 00400030 1 0c ffdeadbe
2 240d000c 00400034 1 0d 0000000c
2 01a17004 00400038 1 0e 01234000
2 01a27806 0040003c 1 0f 000deadb
2 01a58007 00400040 1 10 ffffffff
2 00a1882a 00400044 1 11 00000001
2 00a1902b 00400048 1 12 00000000
2 00249823 0040004c 1 13 ffff2469
2 7024a002 00400050 1 14 10e8933c
3 24150005 00400054 1 15 00000005
3 02b5b021 00400058 1 16 0000000a
3 02d5b821 0040005c 1 17 0000000f
3 02f5c023 00400060 1 18 0000000a
3 0018c080 00400064 1 18 00000028
3 0317c821 00400068 1 19 00000037
4 241a0040 0040006c 1 1a 00000040
4 af420008 00400070 0 00 00000000
4 8f5b0008 00400074 1 1b deadbeef
4 0361e021 00400078 1 1c deadd123
4 241d7777 0040007c 1 1d 00007777
4 af5d000c 00400080 0 00 00000000
4 8f5e000c 00400084 1 1e 00007777
5 0c000040 00400088 1 1f 00400090
5 24000055 0040008c 1 00 00000055
5 001f1821 00400090 1 03 00400090
5 fc000000 00400094 0 00 00000000

// ==== tests/core_tb.sv ====
`include "core_settings.svh"

module core_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned SEED           = 32'h576f10bc;
  localparam int          RETIRE_TIMEOUT = 20;
  localparam int          QUIET_CYCLES   = 5;
  localparam string       STIM_FILE      = "tests/core_stimulus.txt";

  typedef struct packed {
    logic [7:0]            grp;
    logic [`CORE_XLEN-1:0] pc;
    core_pkg::retire_t     ret;
  } retire_exp_t;

  logic                  clk = 1'b0;
  logic                  rst;
  logic                  inst_valid;
  logic [`CORE_XLEN-1:0] inst;
  logic [`CORE_XLEN-1:0] pc;
  logic                  retire_valid;
  core_pkg::retire_t     retire;

  logic [`CORE_XLEN-1:0] inst_list [$];
  logic [`CORE_XLEN-1:0] pc_list [$];
  int                    gap_list [$];
  retire_exp_t           exp_list [$];
  retire_exp_t           expect_q [$];
  int                    num_insts = 0;
  int                    total_checks = 0;
  int                    total_errors = 0;
  int                    grp_checks = 0;
  int                    grp_errors = 0;
  logic                  timed_out = 1'b0;

  string group_name [6] = '{"reset", "immediates and logic", "shifts, compares, subu, mul",
                            "back-to-back forwarding", "store, load and load-use",
                            "jal, register 0, no-write"};

  core_top UUT (
    .clk          (clk),
    .rst          (rst),
    .inst_valid   (inst_valid),
    .inst         (inst),
    .pc           (pc),
    .retire_valid (retire_valid),
    .retire       (retire)
  );

  always #4 clk = ~clk;

  task automatic record_failure(input string msg);
    $display("%s", msg);
    total_errors++;
    grp_errors++;
  endtask

  task automatic report_group(input logic [7:0] grp);
    $display("Test %0d (%s): %0d checks, %0d errors", grp,
             (grp < 6) ? group_name[grp] : "unnamed", grp_checks, grp_errors);
    grp_checks = 0;
    grp_errors = 0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus file
  //////////////////////////////////////////////////////////////////////

  task automatic load_stimulus();
    int                    fd;
    int                    n;
    string                 line;
    logic [7:0]            grp;
    logic [`CORE_XLEN-1:0] word;
    logic [`CORE_XLEN-1:0] addr;
    logic                  we;
    logic [4:0]            rd;
    logic [`CORE_XLEN-1:0] data;
    retire_exp_t           exp;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      record_failure("Could not open the stimulus file");
      return;
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line.getc(0) == "#")
        continue;
      n = $sscanf(line, "%h %h %h %h %h %h", grp, word, addr, we, rd, data);
      if (n != 6) begin
        record_failure({"Stimulus line could not be parsed: ", line});
        continue;
      end
      exp.grp = grp;
      exp.pc  = addr;
      exp.ret = '{we: we, rd: rd, data: data};
      inst_list.push_back(word);
      pc_list.push_back(addr);
      exp_list.push_back(exp);
      // Idle cycles before this instruction
      // Dependent sequences from group 3 on run back to back
      if (grp >= 8'd3)
        gap_list.push_back(0);
      else
        gap_list.push_back($urandom_range(2, 0));
    end
    $fclose(fd);
    num_insts = inst_list.size();
    if (num_insts == 0)
      record_failure("Stimulus file holds no instructions");
  endtask

  //////////////////////////////////////////////////////////////////////
  // Driver and checker
  //////////////////////////////////////////////////////////////////////

  task automatic drive_stream();
    for (int i = 0; i < num_insts; i++) begin
      repeat (gap_list[i]) begin
        @(posedge clk);
        inst_valid <= 1'b0;
      end
      @(posedge clk);
      inst_valid <= 1'b1;
      inst       <= inst_list[i];
      pc         <= pc_list[i];
      expect_q.push_back(exp_list[i]);
    end
    @(posedge clk);
    inst_valid <= 1'b0;
  endtask

  task automatic check_idle(input string when_seen);
    grp_checks++;
    total_checks++;
    if (retire_valid !== 1'b0)
      record_failure($sformatf("Mismatch retire_valid %s: expected 0x0, got 0x%0h",
                               when_seen, retire_valid));
  endtask

  task automatic compare_retire(input retire_exp_t exp);
    grp_checks++;
    total_checks++;
    if (retire.we !== exp.ret.we)
      record_failure($sformatf("Mismatch retire.we: expected 0x%0h, got 0x%0h (pc 0x%08h)",
                               exp.ret.we, retire.we, exp.pc));
    // Destination and data only matter for a register write
    if (exp.ret.we) begin
      if (retire.rd !== exp.ret.rd)
        record_failure($sformatf("Mismatch retire.rd: expected 0x%02h, got 0x%02h (pc 0x%08h)",
                                 exp.ret.rd, retire.rd, exp.pc));
      if (retire.data !== exp.ret.data)
        record_failure($sformatf("Mismatch retire.data: expected 0x%08h, got 0x%08h (pc 0x%08h)",
                                 exp.ret.data, retire.data, exp.pc));
    end
  endtask

  task automatic check_stream();
    retire_exp_t exp;
    int          waited;
    logic [7:0]  cur_grp;
    cur_grp = 8'd1;
    for (int i = 0; i < num_insts && !timed_out; i++) begin
      waited = 0;
      @(negedge clk);
      while (retire_valid !== 1'b1 && waited < RETIRE_TIMEOUT) begin
        @(negedge clk);
        waited++;
      end
      if (retire_valid !== 1'b1) begin
        record_failure($sformatf("No retirement within %0d cycles, %0d instructions outstanding",
                                 RETIRE_TIMEOUT, num_insts - i));
        timed_out = 1'b1;
      end else if (expect_q.size() == 0) begin
        record_failure("Retirement seen with no instruction outstanding");
      end else begin
        exp = expect_q.pop_front();
        if (exp.grp != cur_grp) begin
          report_group(cur_grp);
          cur_grp = exp.grp;
        end
        compare_retire(exp);
      end
    end
    report_group(cur_grp);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    rst        = 1'b1;
    inst_valid = 1'b0;
    inst       = '0;
    pc         = '0;
    void'($urandom(SEED));
    load_stimulus();

    // Nothing may retire during the three reset edges
    repeat (2) begin
      @(posedge clk);
      @(negedge clk);
      check_idle("during reset");
    end
    @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_idle("after reset release");
    report_group(8'd0);

    fork
      drive_stream();
      check_stream();
    join

    if (!timed_out) begin
      for (int i = 0; i < QUIET_CYCLES; i++) begin
        @(negedge clk);
        if (retire_valid !== 1'b0)
          record_failure("Extra retirement after the last instruction");
      end
    end

    $display("Summary: %0d checks, %0d errors", total_checks, total_errors);
    if (total_errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== hw/core_top.sv ====
`include "core_settings.svh"

module core_top (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  inst_valid,
  input  logic [`CORE_XLEN-1:0] inst,
  input  logic [`CORE_XLEN-1:0] pc,
  output logic                  retire_valid,
  output core_pkg::retire_t     retire
);

  logic [`CORE_REG_AW-1:0] rs_addr;
  logic [`CORE_REG_AW-1:0] rt_addr;
  logic [`CORE_XLEN-1:0]   rs_data;
  logic [`CORE_XLEN-1:0]   rt_data;
  logic [`CORE_XLEN-1:0]   load_data;
  logic [`CORE_XLEN-1:0]   mem_result;
  logic                    ex_valid;
  logic                    mem_valid;
  logic                    wb_valid;
  logic                    mem_we;
  core_pkg::fwd_sel_e      fwd_a;
  core_pkg::fwd_sel_e      fwd_b;

  core_pkg::id_ex_t  id_ex_d;
  core_pkg::id_ex_t  id_ex_q;
  core_pkg::ex_mem_t ex_mem_d;
  core_pkg::ex_mem_t ex_mem_q;
  core_pkg::mem_wb_t mem_wb_q;

  inst_decode u_decode (
    .inst    (inst),
    .pc      (pc),
    .rs_data (rs_data),
    .rt_data (rt_data),
    .rs_addr (rs_addr),
    .rt_addr (rt_addr),
    .id_ex   (id_ex_d)
  );

  reg_file u_regs (
    .clk     (clk),
    .rst     (rst),
    .rs_addr (rs_addr),
    .rt_addr (rt_addr),
    .we      (wb_valid && mem_wb_q.we),
    .wr_addr (mem_wb_q.rd),
    .wr_data (mem_wb_q.result),
    .rs_data (rs_data),
    .rt_data (rt_data)
  );

  exe u_exe (
    .id_ex      (id_ex_q),
    .fwd_a      (fwd_a),
    .fwd_b      (fwd_b),
    .exm_result (mem_result),
    .mwb_result (mem_wb_q.result),
    .ex_mem     (ex_mem_d)
  );

  data_mem u_dmem (
    .clk     (clk),
    .addr    (ex_mem_q.addr),
    .we      (mem_we),
    .wr_data (ex_mem_q.store_data),
    .rd_data (load_data)
  );

  pipe_ctrl u_ctrl (
    .clk        (clk),
    .rst        (rst),
    .inst_valid (inst_valid),
    .id_ex      (id_ex_q),
    .ex_mem     (ex_mem_q),
    .mem_wb     (mem_wb_q),
    .ex_valid   (ex_valid),
    .mem_valid  (mem_valid),
    .wb_valid   (wb_valid),
    .mem_we     (mem_we),
    .fwd_a      (fwd_a),
    .fwd_b      (fwd_b)
  );

  // Loads take the memory word, everything else the ALU result
  assign mem_result = (ex_mem_q.mem_op == core_pkg::MEM_LW) ? load_data : ex_mem_q.result;

  // Stage payloads, qualified by the valid bits in pipe_ctrl
  always_ff @(posedge clk) begin
    if (inst_valid)
      id_ex_q <= id_ex_d;
    if (ex_valid)
      ex_mem_q <= ex_mem_d;
    if (mem_valid)
      mem_wb_q <= '{result: mem_result, rd: ex_mem_q.rd, we: ex_mem_q.we};
  end

  assign retire_valid = wb_valid;
  assign retire       = '{we: mem_wb_q.we, rd: mem_wb_q.rd, data: mem_wb_q.result};

endmodule

// ==== hw/pipe_ctrl.sv ====
`include "core_settings.svh"

module pipe_ctrl (
  input  logic                clk,
  input  logic                rst,
  input  logic                inst_valid,
  input  core_pkg::id_ex_t    id_ex,
  input  core_pkg::ex_mem_t   ex_mem,
  input  core_pkg::mem_wb_t   mem_wb,
  output logic                ex_valid,
  output logic                mem_valid,
  output logic                wb_valid,
  output logic                mem_we,
  output core_pkg::fwd_sel_e  fwd_a,
  output core_pkg::fwd_sel_e  fwd_b
);

  //////////////////////////////////////////////////////////////////////
  // Stage valid bits
  //////////////////////////////////////////////////////////////////////

  // Valid bits shift every cycle since nothing stalls
  always_ff @(posedge clk) begin
    if (rst) begin
      ex_valid  <= 1'b0;
      mem_valid <= 1'b0;
      wb_valid  <= 1'b0;
    end else begin
      ex_valid  <= inst_valid;
      mem_valid <= ex_valid;
      wb_valid  <= mem_valid;
    end
  end

  assign mem_we = mem_valid && ex_mem.mem_op == core_pkg::MEM_SW;

  //////////////////////////////////////////////////////////////////////
  // Forwarding selects
  //////////////////////////////////////////////////////////////////////

  function automatic core_pkg::fwd_sel_e pick_src(
    input logic                    use_src,
    input logic [`CORE_REG_AW-1:0] src
  );
    if (!use_src || src == '0)
      return core_pkg::FWD_REG;
    // Youngest producer wins
    if (mem_valid && ex_mem.we && ex_mem.rd == src)
      return core_pkg::FWD_EXM;
    if (wb_valid && mem_wb.we && mem_wb.rd == src)
      return core_pkg::FWD_MWB;
    return core_pkg::FWD_REG;
  endfunction

  always_comb begin
    fwd_a = pick_src(id_ex.use_rs, id_ex.rs);
    fwd_b = pick_src(id_ex.use_rt, id_ex.rt);
  end

  // Fixed three cycle latency from strobe to retirement
  a_retire_latency: assert property (
    @(posedge clk) disable iff (rst) inst_valid |-> ##3 wb_valid
  );

endmodule

// ==== hw/data_mem.sv ====
`include "core_settings.svh"

module data_mem (
  input  logic                  clk,
  input  logic [`CORE_XLEN-1:0] addr,
  input  logic                  we,
  input  logic [`CORE_XLEN-1:0] wr_data,
  output logic [`CORE_XLEN-1:0] rd_data
);

  logic [`CORE_XLEN-1:0]    mem [`CORE_DMEM_WORDS];
  logic [`CORE_DMEM_AW-1:0] word_idx;

  // Byte address to word index
  assign word_idx = addr[`CORE_DMEM_AW+1:2];

  // Load data is ready in the same cycle
  assign rd_data = mem[word_idx];

  always_ff @(posedge clk) begin
    if (we)
      mem[word_idx] <= wr_data;
  end

  // Only whole aligned words are stored
  a_store_aligned: assert property (
    @(posedge clk) we |-> addr[1:0] == 2'b00
  );

endmodule

// ==== hw/exe.sv ====
`include "core_settings.svh"

module exe (
  input  core_pkg::id_ex_t      id_ex,
  input  core_pkg::fwd_sel_e    fwd_a,
  input  core_pkg::fwd_sel_e    fwd_b,
  input  logic [`CORE_XLEN-1:0] exm_result,
  input  logic [`CORE_XLEN-1:0] mwb_result,
  output core_pkg::ex_mem_t     ex_mem
);

  logic [`CORE_XLEN-1:0] src_a;
  logic [`CORE_XLEN-1:0] src_b;
  logic [`CORE_XLEN-1:0] src_st;
  logic [`CORE_XLEN-1:0] op_a;
  logic [`CORE_XLEN-1:0] op_b;
  logic [`CORE_XLEN-1:0] result;

  // Pick the newest copy of a source register
  function automatic logic [`CORE_XLEN-1:0] fwd_mux(
    input core_pkg::fwd_sel_e    sel,
    input logic [`CORE_XLEN-1:0] reg_val
  );
    case (sel)
      core_pkg::FWD_EXM: return exm_result;
      core_pkg::FWD_MWB: return mwb_result;
      default:           return reg_val;
    endcase
  endfunction

  always_comb begin
    src_a  = fwd_mux(fwd_a, id_ex.a_val);
    src_b  = fwd_mux(fwd_b, id_ex.b_val);
    src_st = fwd_mux(fwd_b, id_ex.store_data);
    op_a   = id_ex.imm_a ? id_ex.imm_val : src_a;
    op_b   = id_ex.imm_b ? id_ex.imm_val : src_b;
  end

  //////////////////////////////////////////////////////////////////////
  // ALU
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (id_ex.alu_op)
      core_pkg::ALU_AND:  result = op_a & op_b;
      core_pkg::ALU_OR:   result = op_a | op_b;
      core_pkg::ALU_XOR:  result = op_a ^ op_b;
      core_pkg::ALU_NOR:  result = ~(op_a | op_b);
      // Shift amount in operand a, value in operand b
      core_pkg::ALU_SLL:  result = op_b << op_a[4:0];
      core_pkg::ALU_SRL:  result = op_b >> op_a[4:0];
      core_pkg::ALU_SRA:  result = $signed(op_b) >>> op_a[4:0];
      core_pkg::ALU_SLT:  result = {{(`CORE_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      core_pkg::ALU_SLTU: result = {{(`CORE_XLEN-1){1'b0}}, op_a < op_b};
      core_pkg::ALU_ADD:  result = op_a + op_b;
      core_pkg::ALU_SUB:  result = op_a + ~op_b + `CORE_XLEN'd1;
      // Low half of the unsigned product
      core_pkg::ALU_MUL:  result = op_a * op_b;
      core_pkg::ALU_LUI:  result = op_b;
      core_pkg::ALU_LINK: result = id_ex.link;
      default:            result = '0;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Memory request and result
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    ex_mem.mem_op     = id_ex.mem_op;
    ex_mem.addr       = src_a + id_ex.offset;
    ex_mem.store_data = src_st;
    ex_mem.result     = result;
    ex_mem.rd         = id_ex.rd;
    ex_mem.we         = id_ex.we;
  end

endmodule

// ==== hw/inst_decode.sv ====
`include "core_settings.svh"

module inst_decode (
  input  logic [`CORE_XLEN-1:0]   inst,
  input  logic [`CORE_XLEN-1:0]   pc,
  input  logic [`CORE_XLEN-1:0]   rs_data,
  input  logic [`CORE_XLEN-1:0]   rt_data,
  output logic [`CORE_REG_AW-1:0] rs_addr,
  output logic [`CORE_REG_AW-1:0] rt_addr,
  output core_pkg::id_ex_t        id_ex
);

  core_pkg::opcode_e     opcode;
  core_pkg::funct_e      funct;
  logic [`CORE_XLEN-1:0] imm_sext;
  logic [`CORE_XLEN-1:0] imm_zext;
  logic [`CORE_XLEN-1:0] shamt;

  assign opcode   = core_pkg::opcode_e'(inst[31:26]);
  assign funct    = core_pkg::funct_e'(inst[5:0]);
  assign rs_addr  = inst[25:21];
  assign rt_addr  = inst[20:16];
  assign imm_sext = {{(`CORE_XLEN-16){inst[15]}}, inst[15:0]};
  assign imm_zext = {{(`CORE_XLEN-16){1'b0}}, inst[15:0]};
  assign shamt    = {{(`CORE_XLEN-5){1'b0}}, inst[10:6]};

  always_comb begin
    // Defaults describe a no-op that writes nothing
    id_ex            = '0;
    id_ex.alu_op     = core_pkg::ALU_ADD;
    id_ex.mem_op     = core_pkg::MEM_NOP;
    id_ex.a_val      = rs_data;
    id_ex.b_val      = rt_data;
    id_ex.rs         = rs_addr;
    id_ex.rt         = rt_addr;
    id_ex.offset     = imm_sext;
    id_ex.link       = pc + `CORE_XLEN'd8;

    case (opcode)
      core_pkg::OP_SPECIAL: begin
        id_ex.rd     = inst[15:11];
        id_ex.we     = 1'b1;
        id_ex.use_rs = 1'b1;
        id_ex.use_rt = 1'b1;
        case (funct)
          core_pkg::FN_SLL, core_pkg::FN_SRL, core_pkg::FN_SRA: begin
            // Shift amount comes from the instruction, rs is ignored
            id_ex.use_rs  = 1'b0;
            id_ex.imm_a   = 1'b1;
            id_ex.imm_val = shamt;
            id_ex.alu_op  = (funct == core_pkg::FN_SLL) ? core_pkg::ALU_SLL :
                            (funct == core_pkg::FN_SRL) ? core_pkg::ALU_SRL :
                                                          core_pkg::ALU_SRA;
          end
          core_pkg::FN_SLLV: id_ex.alu_op = core_pkg::ALU_SLL;
          core_pkg::FN_SRLV: id_ex.alu_op = core_pkg::ALU_SRL;
          core_pkg::FN_SRAV: id_ex.alu_op = core_pkg::ALU_SRA;
          core_pkg::FN_ADDU: id_ex.alu_op = core_pkg::ALU_ADD;
          core_pkg::FN_SUBU: id_ex.alu_op = core_pkg::ALU_SUB;
          core_pkg::FN_AND:  id_ex.alu_op = core_pkg::ALU_AND;
          core_pkg::FN_OR:   id_ex.alu_op = core_pkg::ALU_OR;
          core_pkg::FN_XOR:  id_ex.alu_op = core_pkg::ALU_XOR;
          core_pkg::FN_NOR:  id_ex.alu_op = core_pkg::ALU_NOR;
          core_pkg::FN_SLT:  id_ex.alu_op = core_pkg::ALU_SLT;
          core_pkg::FN_SLTU: id_ex.alu_op = core_pkg::ALU_SLTU;
          default:           id_ex.we     = 1'b0;
        endcase
      end
      core_pkg::OP_SPECIAL2: begin
        id_ex.rd     = inst[15:11];
        id_ex.alu_op = core_pkg::ALU_MUL;
        id_ex.use_rs = 1'b1;
        id_ex.use_rt = 1'b1;
        id_ex.we     = (inst[5:0] == core_pkg::FN2_MUL);
      end
      core_pkg::OP_ADDIU, core_pkg::OP_ANDI, core_pkg::OP_ORI, core_pkg::OP_XORI: begin
        id_ex.rd      = rt_addr;
        id_ex.we      = 1'b1;
        id_ex.use_rs  = 1'b1;
        id_ex.imm_b   = 1'b1;
        id_ex.imm_val = (opcode == core_pkg::OP_ADDIU) ? imm_sext : imm_zext;
        id_ex.alu_op  = (opcode == core_pkg::OP_ADDIU) ? core_pkg::ALU_ADD :
                        (opcode == core_pkg::OP_ANDI)  ? core_pkg::ALU_AND :
                        (opcode == core_pkg::OP_ORI)   ? core_pkg::ALU_OR  :
                                                         core_pkg::ALU_XOR;
      end
      core_pkg::OP_LUI: begin
        id_ex.rd      = rt_addr;
        id_ex.we      = 1'b1;
        id_ex.alu_op  = core_pkg::ALU_LUI;
        id_ex.imm_b   = 1'b1;
        id_ex.imm_val = {inst[15:0], 16'h0000};
      end
      core_pkg::OP_LW: begin
        id_ex.rd     = rt_addr;
        id_ex.we     = 1'b1;
        id_ex.use_rs = 1'b1;
        id_ex.mem_op = core_pkg::MEM_LW;
      end
      core_pkg::OP_SW: begin
        id_ex.use_rs     = 1'b1;
        id_ex.use_rt     = 1'b1;
        id_ex.mem_op     = core_pkg::MEM_SW;
        id_ex.store_data = rt_data;
      end
      core_pkg::OP_JAL: begin
        id_ex.rd     = `CORE_REG_AW'(`CORE_LINK_REG);
        id_ex.we     = 1'b1;
        id_ex.alu_op = core_pkg::ALU_LINK;
      end
      default: ;
    endcase
  end

endmodule

// ==== hw/reg_file.sv ====
`include "core_settings.svh"

module reg_file (
  input  logic                    clk,
  input  logic                    rst,
  input  logic [`CORE_REG_AW-1:0] rs_addr,
  input  logic [`CORE_REG_AW-1:0] rt_addr,
  input  logic                    we,
  input  logic [`CORE_REG_AW-1:0] wr_addr,
  input  logic [`CORE_XLEN-1:0]   wr_data,
  output logic [`CORE_XLEN-1:0]   rs_data,
  output logic [`CORE_XLEN-1:0]   rt_data
);

  // No storage behind register 0
  logic [`CORE_XLEN-1:0] regs [1:`CORE_REGS-1];

  function automatic logic [`CORE_XLEN-1:0] read_port(input logic [`CORE_REG_AW-1:0] addr);
    if (addr == '0)
      return '0;
    // Write-through from the port being written this cycle
    if (we && wr_addr == addr)
      return wr_data;
    return regs[addr];
  endfunction

  always_comb begin
    rs_data = read_port(rs_addr);
    rt_data = read_port(rt_addr);
  end

  always_ff @(posedge clk) begin
    if (we && wr_addr != '0)
      regs[wr_addr] <= wr_data;
  end

  a_wr_addr_known: assert property (
    @(posedge clk) disable iff (rst) we |-> !$isunknown(wr_addr)
  );

endmodule

// ==== hw/core_pkg.sv ====
`include "core_settings.svh"

package core_pkg;

  //////////////////////////////////////////////////////////////////////
  // Instruction encodings
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [5:0] {
    OP_SPECIAL  = 6'h00,
    OP_JAL      = 6'h03,
    OP_ADDIU    = 6'h09,
    OP_ANDI     = 6'h0c,
    OP_ORI      = 6'h0d,
    OP_XORI     = 6'h0e,
    OP_LUI      = 6'h0f,
    OP_SPECIAL2 = 6'h1c,
    OP_LW       = 6'h23,
    OP_SW       = 6'h2b
  } opcode_e;

  // Function field of SPECIAL
  typedef enum logic [5:0] {
    FN_SLL  = 6'h00,
    FN_SRL  = 6'h02,
    FN_SRA  = 6'h03,
    FN_SLLV = 6'h04,
    FN_SRLV = 6'h06,
    FN_SRAV = 6'h07,
    FN_ADDU = 6'h21,
    FN_SUBU = 6'h23,
    FN_AND  = 6'h24,
    FN_OR   = 6'h25,
    FN_XOR  = 6'h26,
    FN_NOR  = 6'h27,
    FN_SLT  = 6'h2a,
    FN_SLTU = 6'h2b
  } funct_e;

  // SPECIAL2 mul shares its code with srl
  localparam logic [5:0] FN2_MUL = 6'h02;

  typedef enum logic [4:0] {
    ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
    ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_SLT, ALU_SLTU,
    ALU_ADD, ALU_SUB, ALU_MUL,
    ALU_LUI, ALU_LINK
  } alu_op_e;

  typedef enum logic [1:0] {MEM_NOP, MEM_LW, MEM_SW} mem_op_e;

  typedef enum logic [1:0] {FWD_REG, FWD_EXM, FWD_MWB} fwd_sel_e;

  //////////////////////////////////////////////////////////////////////
  // Stage registers
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    alu_op_e                 alu_op;
    mem_op_e                 mem_op;
    logic [`CORE_XLEN-1:0]   a_val;
    logic [`CORE_XLEN-1:0]   b_val;
    logic [`CORE_REG_AW-1:0] rs;
    logic [`CORE_REG_AW-1:0] rt;
    logic                    use_rs;
    logic                    use_rt;
    // Shamt replaces operand a, immediates replace operand b
    logic                    imm_a;
    logic                    imm_b;
    logic [`CORE_XLEN-1:0]   imm_val;
    logic [`CORE_XLEN-1:0]   store_data;
    logic [`CORE_REG_AW-1:0] rd;
    logic                    we;
    logic [`CORE_XLEN-1:0]   offset;
    logic [`CORE_XLEN-1:0]   link;
  } id_ex_t;

  typedef struct packed {
    mem_op_e                 mem_op;
    logic [`CORE_XLEN-1:0]   addr;
    logic [`CORE_XLEN-1:0]   store_data;
    logic [`CORE_XLEN-1:0]   result;
    logic [`CORE_REG_AW-1:0] rd;
    logic                    we;
  } ex_mem_t;

  typedef struct packed {
    logic [`CORE_XLEN-1:0]   result;
    logic [`CORE_REG_AW-1:0] rd;
    logic                    we;
  } mem_wb_t;

  typedef struct packed {
    logic                    we;
    logic [`CORE_REG_AW-1:0] rd;
    logic [`CORE_XLEN-1:0]   data;
  } retire_t;

endpackage

// ==== hw/core_settings.svh ====
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Datapath width
`define CORE_XLEN 32

// Architectural register file
`define CORE_REGS 32
`define CORE_REG_AW 5

// Data memory, word addressed
`define CORE_DMEM_WORDS 256
`define CORE_DMEM_AW 8

// Destination of jal
`define CORE_LINK_REG 31

`endif
